// File: Bender.yml
package:
  name: icache

sources:
  - files:
      - rtl/cache_pkg.sv
      - rtl/axi_rd_pkg.sv
      - rtl/icache_tag_array.sv
      - rtl/icache_data_array.sv
      - rtl/icache_refill_ctrl.sv
      - rtl/icache_top.sv
  - target: test
    files:
      - testbench/icache_sva.sv
      - testbench/icache_tb.sv

// File: rtl/axi_rd_pkg.sv
`default_nettype none

package axi_rd_pkg;

	// burst type INCR
	localparam logic [1:0] burst_incr = 2'b01;
	// 8 bytes per beat
	localparam logic [2:0] beat_size_8b = 3'd3;

	// read address channel, master to slave
	typedef struct packed {
		logic [31:0] addr;
		logic [7:0]  len;
		logic [2:0]  size;
		logic [1:0]  burst;
		logic        valid;
	} axi_ar_t;

	// read data channel, slave to master
	// resp travels along but the cache does not look at it
	typedef struct packed {
		logic [63:0] data;
		logic [1:0]  resp;
		logic        last;
		logic        valid;
	} axi_r_t;

endpackage

`default_nettype wire

// File: rtl/cache_pkg.sv
`default_nettype none

package cache_pkg;

	// geometry of the instruction cache
	localparam int num_sets       = 16;
	localparam int line_bytes     = 64;
	localparam int beats_per_line = 8;
	localparam int tag_w          = 22;
	localparam int idx_w          = 4;

	// lookup view of a fetch address
	// row picks one 128-bit row of the line, word one instruction in it
	typedef struct packed {
		logic [tag_w-1:0] tag;
		logic [idx_w-1:0] index;
		logic [1:0]       row;
		logic [1:0]       word;
		logic [1:0]       byte_off;
	} fetch_fields_t;

	// one address word, read as raw byte address or as lookup fields
	typedef union packed {
		logic [31:0]   raw;
		fetch_fields_t fld;
	} fetch_addr_u;

	// request from the fetch stage
	typedef struct packed {
		logic        valid;
		fetch_addr_u addr;
	} fetch_req_t;

	// one-cycle response pulse towards decode
	typedef struct packed {
		logic        valid;
		logic [31:0] inst;
	} fetch_rsp_t;

	// store address seen by the core, used to drop stale lines
	typedef struct packed {
		logic        valid;
		fetch_addr_u addr;
	} inval_req_t;

endpackage

`default_nettype wire

// File: rtl/icache_data_array.sv
`timescale 1ns/1ps
`default_nettype none

module icache_data_array #(
	parameter int num_ways = 4
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   flush,
	input  cache_pkg::fetch_req_t  req,
	input  logic [num_ways-1:0]    hit_way,
	input  logic                   beat_en,
	input  logic [2:0]             beat_num,
	input  logic [63:0]            beat_data,
	input  logic [num_ways-1:0]    fill_way,
	input  cache_pkg::fetch_addr_u fill_addr,
	output cache_pkg::fetch_rsp_t  rsp
);
	import cache_pkg::*;

	// four 128-bit rows per line
	localparam int row_aw       = idx_w + 2;
	localparam int rows_per_way = num_sets * 4;

	logic [127:0] row_mem [num_ways][rows_per_way];
	// registered row out of each way, like an sram read port
	logic [127:0] row_q [num_ways];
	logic [num_ways-1:0] way_q;
	logic [1:0]          word_q;
	logic                rsp_valid_q;
	logic [127:0]        sel_row;
	logic [row_aw-1:0]   rd_row;
	logic [row_aw-1:0]   wr_row;
	logic                hit;

	assign rd_row = {req.addr.fld.index, req.addr.fld.row};
	// two beats per row, beat_num[0] picks the half
	assign wr_row = {fill_addr.fld.index, beat_num[2:1]};
	assign hit    = req.valid && (hit_way != '0);

	always_ff @(posedge clk) begin
		for (int w = 0; w < num_ways; w++) begin
			if (beat_en && fill_way[w]) begin
				row_mem[w][wr_row][{beat_num[0], 6'b0} +: 64] <= beat_data;
			end
			// only the hitting way is read
			if (req.valid && hit_way[w]) begin
				row_q[w] <= row_mem[w][rd_row];
			end
		end
		if (hit) begin
			way_q  <= hit_way;
			word_q <= req.addr.fld.word;
		end
	end

	// response pulse one cycle after a hit, killed by flush
	always_ff @(posedge clk) begin
		if (rst) begin
			rsp_valid_q <= 1'b0;
		end else if (flush) begin
			rsp_valid_q <= 1'b0;
		end else begin
			rsp_valid_q <= hit;
		end
	end

	// one-hot way mux
	always_comb begin
		sel_row = '0;
		for (int w = 0; w < num_ways; w++) begin
			if (way_q[w]) begin
				sel_row = sel_row | row_q[w];
			end
		end
	end

	assign rsp.valid = rsp_valid_q;
	// word offset picks the instruction inside the row
	assign rsp.inst  = sel_row[{word_q, 5'b0} +: 32];

endmodule

`default_nettype wire

// File: rtl/icache_refill_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module icache_refill_ctrl #(
	parameter int num_ways = 4
) (
	input  logic                   clk,
	input  logic                   rst,
	input  cache_pkg::fetch_req_t  req,
	input  logic [num_ways-1:0]    hit_way,
	output axi_rd_pkg::axi_ar_t    ar,
	input  logic                   arready,
	input  axi_rd_pkg::axi_r_t     r,
	output logic                   rready,
	output logic                   idle,
	output logic                   fill_en,
	output logic [num_ways-1:0]    fill_way,
	output cache_pkg::fetch_addr_u fill_addr,
	output logic                   beat_en,
	output logic [2:0]             beat_num,
	output logic [63:0]            beat_data
);
	import cache_pkg::*;
	import axi_rd_pkg::*;

	// byte offset bits inside a line
	localparam int off_w = $clog2(line_bytes);

	typedef enum logic {
		st_idle,
		st_refill
	} state_t;

	state_t state_q;
	state_t state_d;
	logic   miss;
	logic   ar_hs;
	logic   r_hs;
	// one-hot victim pointer
	logic [num_ways-1:0] victim_q;
	logic [num_ways-1:0] fill_way_q;
	fetch_addr_u         miss_addr_q;
	logic [2:0]          beat_cnt_q;

	assign idle  = (state_q == st_idle);
	assign miss  = idle && req.valid && (hit_way == '0);
	assign ar_hs = miss && arready;
	// cache never stalls read data
	assign rready = 1'b1;
	assign r_hs   = (state_q == st_refill) && r.valid && rready;

	// line burst request, raised in the cycle of the miss
	always_comb begin
		ar.valid = miss;
		ar.addr  = {req.addr.raw[31:off_w], {off_w{1'b0}}};
		ar.len   = 8'(beats_per_line - 1);
		ar.size  = beat_size_8b;
		ar.burst = burst_incr;
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			st_idle: begin
				if (ar_hs) begin
					state_d = st_refill;
				end
			end
			st_refill: begin
				// back to lookup after the last beat
				if (r_hs && r.last) begin
					state_d = st_idle;
				end
			end
			default: begin
				state_d = st_idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q    <= st_idle;
			victim_q   <= num_ways'(1);
			beat_cnt_q <= '0;
		end else begin
			state_q <= state_d;
			// rotate on each idle cycle, looks random from outside
			if (idle) begin
				victim_q <= (victim_q << 1) | (victim_q >> (num_ways - 1));
			end
			if (ar_hs) begin
				beat_cnt_q <= '0;
			end else if (r_hs) begin
				beat_cnt_q <= beat_cnt_q + 3'd1;
			end
		end
	end

	// miss address and way held for the whole burst
	always_ff @(posedge clk) begin
		if (ar_hs) begin
			miss_addr_q <= req.addr;
			fill_way_q  <= victim_q;
		end
	end

	assign beat_en   = r_hs;
	assign beat_num  = beat_cnt_q;
	assign beat_data = r.data;
	// tag and valid written with the final beat
	assign fill_en   = r_hs && r.last;
	assign fill_way  = fill_way_q;
	assign fill_addr = miss_addr_q;

endmodule

`default_nettype wire

// File: rtl/icache_tag_array.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tag_array #(
	parameter int num_ways = 4
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   idle,
	input  cache_pkg::fetch_addr_u lookup_addr,
	input  cache_pkg::inval_req_t  inval,
	input  logic                   fill_en,
	input  logic [num_ways-1:0]    fill_way,
	input  cache_pkg::fetch_addr_u fill_addr,
	output logic [num_ways-1:0]    hit_way
);
	import cache_pkg::*;

	// stored tags per way and set
	logic [tag_w-1:0] tag_mem [num_ways][num_sets];
	// one valid bit per set, per way
	logic [num_sets-1:0] valid_q [num_ways];

	logic [idx_w-1:0] lk_idx;
	logic [idx_w-1:0] fill_idx;
	logic [idx_w-1:0] inv_idx;
	// invalidate to the set being filled this cycle
	logic fill_blocked;

	assign lk_idx   = lookup_addr.fld.index;
	assign fill_idx = fill_addr.fld.index;
	assign inv_idx  = inval.addr.fld.index;
	assign fill_blocked = inval.valid && (inv_idx == fill_idx);

	// compare all ways at once
	// no hit reported while a refill is running
	always_comb begin
		logic tag_eq;
		for (int w = 0; w < num_ways; w++) begin
			tag_eq = (tag_mem[w][lk_idx] == lookup_addr.fld.tag);
			hit_way[w] = idle && valid_q[w][lk_idx] && tag_eq;
		end
	end

	// new tag goes in with the last beat of the burst
	always_ff @(posedge clk) begin
		for (int w = 0; w < num_ways; w++) begin
			if (fill_en && fill_way[w]) begin
				tag_mem[w][fill_idx] <= fill_addr.fld.tag;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < num_ways; w++) begin
				valid_q[w] <= '0;
			end
		end else begin
			for (int w = 0; w < num_ways; w++) begin
				// filled way becomes valid, unless an invalidate hits the same set
				if (fill_en && fill_way[w]) begin
					valid_q[w][fill_idx] <= !fill_blocked;
				end
				// drop every way whose stored tag matches the store address
				// placed last so it overrides a fill
				if (inval.valid && (tag_mem[w][inv_idx] == inval.addr.fld.tag)) begin
					valid_q[w][inv_idx] <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top #(
	parameter int num_ways = 4
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  flush,
	input  cache_pkg::fetch_req_t fetch_req,
	output cache_pkg::fetch_rsp_t fetch_rsp,
	input  cache_pkg::inval_req_t inval,
	output axi_rd_pkg::axi_ar_t   ar,
	input  logic                  arready,
	input  axi_rd_pkg::axi_r_t    r,
	output logic                  rready
);
	import cache_pkg::*;

	// one-hot hit, zero on a miss
	logic [num_ways-1:0] hit_way;
	logic                idle;
	// refill side
	logic                fill_en;
	logic [num_ways-1:0] fill_way;
	fetch_addr_u         fill_addr;
	logic                beat_en;
	logic [2:0]          beat_num;
	logic [63:0]         beat_data;

	icache_tag_array #(
		.num_ways(num_ways)
	) i_tag_array (
		.clk        (clk),
		.rst        (rst),
		.idle       (idle),
		.lookup_addr(fetch_req.addr),
		.inval      (inval),
		.fill_en    (fill_en),
		.fill_way   (fill_way),
		.fill_addr  (fill_addr),
		.hit_way    (hit_way)
	);

	icache_data_array #(
		.num_ways(num_ways)
	) i_data_array (
		.clk      (clk),
		.rst      (rst),
		.flush    (flush),
		.req      (fetch_req),
		.hit_way  (hit_way),
		.beat_en  (beat_en),
		.beat_num (beat_num),
		.beat_data(beat_data),
		.fill_way (fill_way),
		.fill_addr(fill_addr),
		.rsp      (fetch_rsp)
	);

	// miss handling and the AXI read master
	icache_refill_ctrl #(
		.num_ways(num_ways)
	) i_refill_ctrl (
		.clk      (clk),
		.rst      (rst),
		.req      (fetch_req),
		.hit_way  (hit_way),
		.ar       (ar),
		.arready  (arready),
		.r        (r),
		.rready   (rready),
		.idle     (idle),
		.fill_en  (fill_en),
		.fill_way (fill_way),
		.fill_addr(fill_addr),
		.beat_en  (beat_en),
		.beat_num (beat_num),
		.beat_data(beat_data)
	);

endmodule

`default_nettype wire

// File: testbench/icache_sva.sv
`timescale 1ns/1ps
`default_nettype none

module icache_sva (
	input logic                  clk,
	input logic                  rst,
	input logic                  idle,
	input logic                  arready,
	input axi_rd_pkg::axi_ar_t   ar,
	input cache_pkg::fetch_rsp_t fetch_rsp
);
	// number of failed assertions so far
	int fail_count = 0;

	// a pending AR keeps valid and address until the slave takes it
	ar_stable: assert property (@(posedge clk) disable iff (rst)
		(ar.valid && !arready) |=> (ar.valid && $stable(ar.addr)))
		else begin
			fail_count++;
			$error("ar dropped or changed before arready");
		end

	// lookups are gated while a refill runs
	rsp_quiet_in_refill: assert property (@(posedge clk) disable iff (rst)
		!idle |-> !$rose(fetch_rsp.valid))
		else begin
			fail_count++;
			$error("fetch response rose during a refill");
		end

	// no burst request straight out of reset
	ar_low_after_reset: assert property (@(posedge clk)
		rst |=> !ar.valid)
		else begin
			fail_count++;
			$error("ar valid high right after reset");
		end

endmodule

`default_nettype wire

// File: testbench/icache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tb;
	import cache_pkg::*;
	import axi_rd_pkg::*;

	// 16 KB fetch window with 16 tags per set
	// line number is addr[13:6]
	localparam logic [31:0] win_base  = 32'h0004_0000;
	localparam int          rsp_limit = 400;

	logic       clk = 1'b0;
	logic       rst;
	logic       flush;
	fetch_req_t fetch_req;
	fetch_rsp_t fetch_rsp;
	inval_req_t inval;
	axi_ar_t    ar;
	// memory side inputs start low until the memory model takes over
	logic       arready = 1'b0;
	axi_r_t     r = '0;
	logic       rready;

	// reference model
	// maybe_valid is set for any line that could sit in the cache
	bit       maybe_valid [256];
	// last line touched in each set is the only one certain to be present
	bit [7:0] last_line [16];
	bit       last_ok [16];

	// memory model state
	bit          busy;
	int          beat;
	logic [28:0] beat_base;

	always #4 clk = ~clk;

	icache_top #(
		.num_ways(4)
	) i_icache_top (
		.clk      (clk),
		.rst      (rst),
		.flush    (flush),
		.fetch_req(fetch_req),
		.fetch_rsp(fetch_rsp),
		.inval    (inval),
		.ar       (ar),
		.arready  (arready),
		.r        (r),
		.rready   (rready)
	);

	bind icache_top icache_sva i_icache_sva (
		.clk      (clk),
		.rst      (rst),
		.idle     (idle),
		.arready  (arready),
		.ar       (ar),
		.fetch_rsp(fetch_rsp)
	);

	// memory content is a fixed hash of the 64-bit word address
	function automatic logic [63:0] mem_word(input logic [28:0] a);
		logic [31:0] w;
		w = {3'b0, a};
		return {(w * 32'h9e37_79b9) ^ 32'h7f4a_7c15, (w ^ 32'h2545_f491) * 32'h0019_660d};
	endfunction

	// little endian so addr[2] picks the upper half of the beat
	function automatic logic [31:0] expected_inst(input logic [31:0] addr);
		logic [63:0] d;
		d = mem_word(addr[31:3]);
		return addr[2] ? d[63:32] : d[31:0];
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act) begin
			abort_run($sformatf("FAILED %s: expected %0h, actual %0h", name, exp, act));
		end
	endtask

	// outputs are sampled right after the edge and show the cycle just ended
	task automatic fetch_and_check(input string name, input logic [31:0] addr,
			output bit missed);
		bit [7:0] line;
		int       kind;
		int       cycles;
		line = addr[13:6];
		// kind is 2 for a sure miss, 1 for a sure hit and 0 otherwise
		if (!maybe_valid[line]) begin
			kind = 2;
		end else if (last_ok[line[3:0]] && last_line[line[3:0]] == line) begin
			kind = 1;
		end else begin
			kind = 0;
		end
		fetch_req.valid    <= 1'b1;
		fetch_req.addr.raw <= addr;
		missed = 1'b0;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
			if (cycles > rsp_limit) begin
				abort_run($sformatf("no fetch response for address %h within %0d cycles",
					addr, rsp_limit));
			end
			if (ar.valid) begin
				missed = 1'b1;
				check_eq({name, " ar addr"}, {addr[31:6], 6'b0}, ar.addr);
			end
		end while (!fetch_rsp.valid);
		fetch_req.valid <= 1'b0;
		check_eq({name, " inst"}, expected_inst(addr), fetch_rsp.inst);
		if (kind == 1) begin
			check_eq({name, " hit latency"}, 2, cycles);
			check_eq({name, " ar on hit"}, 0, missed);
		end else if (kind == 2) begin
			check_eq({name, " ar on miss"}, 1, missed);
		end
		maybe_valid[line]    = 1'b1;
		last_line[line[3:0]] = line;
		last_ok[line[3:0]]   = 1'b1;
		// request was still up in the response cycle so a repeat response may follow
		@(posedge clk);
		if (fetch_rsp.valid) begin
			check_eq({name, " repeat inst"}, expected_inst(addr), fetch_rsp.inst);
		end
	endtask

	// store address on the invalidate port for one cycle
	task automatic send_inval(input logic [31:0] addr);
		bit [7:0] line;
		line = addr[13:6];
		inval.valid    <= 1'b1;
		inval.addr.raw <= addr;
		@(posedge clk);
		inval.valid <= 1'b0;
		check_eq("inval alone", 0, ar.valid);
		@(posedge clk);
		check_eq("inval alone", 0, ar.valid);
		maybe_valid[line] = 1'b0;
		if (last_line[line[3:0]] == line) begin
			last_ok[line[3:0]] = 1'b0;
		end
	endtask

	// flush raised together with a hit request kills its response
	task automatic flush_hit(input logic [31:0] addr);
		int n;
		fetch_req.valid    <= 1'b1;
		fetch_req.addr.raw <= addr;
		flush              <= 1'b1;
		@(posedge clk);
		fetch_req.valid <= 1'b0;
		flush           <= 1'b0;
		check_eq("flush lookup hit", 0, ar.valid);
		for (n = 0; n < 2; n++) begin
			@(posedge clk);
			check_eq("flush drops response", 0, fetch_rsp.valid);
		end
	endtask

	// miss whose request is flushed and replaced by a cached line once its burst starts
	task automatic swap_during_refill(input logic [31:0] miss_a, input logic [31:0] hit_a);
		bit [7:0] line;
		int       cycles;
		bit       missed;
		line = miss_a[13:6];
		fetch_req.valid    <= 1'b1;
		fetch_req.addr.raw <= miss_a;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
			if (cycles > rsp_limit) begin
				abort_run($sformatf("no AR handshake for address %h within %0d cycles",
					miss_a, rsp_limit));
			end
		end while (!(ar.valid && arready));
		check_eq("swap ar addr", {miss_a[31:6], 6'b0}, ar.addr);
		// requester leaves the miss behind by raising flush for one cycle
		fetch_req.addr.raw <= hit_a;
		flush              <= 1'b1;
		cycles = 0;
		do begin
			@(posedge clk);
			flush <= 1'b0;
			cycles++;
			if (cycles > rsp_limit) begin
				abort_run($sformatf("no last read beat for address %h within %0d cycles",
					miss_a, rsp_limit));
			end
			check_eq("swap no rsp in refill", 0, fetch_rsp.valid);
		end while (!(r.valid && r.last));
		// the burst still filled the missed line
		maybe_valid[line]    = 1'b1;
		last_line[line[3:0]] = line;
		last_ok[line[3:0]]   = 1'b1;
		fetch_and_check("swap hit after refill", hit_a, missed);
	endtask

	// stop at the first failed protocol assertion
	always @(posedge clk) begin
		if (i_icache_top.i_icache_sva.fail_count != 0) begin
			abort_run("a protocol assertion failed");
		end
	end

	// AXI slave with random arready and random gaps between beats
	always @(posedge clk) begin
		if (rst) begin
			busy = 1'b0;
			arready <= 1'b0;
			r       <= '0;
		end else if (!busy) begin
			if (ar.valid && arready) begin
				check_eq("ar len", 7, ar.len);
				check_eq("ar size", 3, ar.size);
				check_eq("ar burst", 1, ar.burst);
				check_eq("ar line aligned", 0, ar.addr[5:0]);
				busy      = 1'b1;
				beat      = 0;
				beat_base = ar.addr[31:3];
				arready  <= 1'b0;
			end else begin
				arready <= ($urandom % 3) != 0;
			end
		end else begin
			// a valid beat was taken at this edge
			if (r.valid) begin
				check_eq("rready", 1, rready);
				beat++;
			end
			if (r.valid && r.last) begin
				busy = 1'b0;
				r.valid <= 1'b0;
				r.last  <= 1'b0;
			end else if ($urandom % 4 == 0) begin
				r.valid <= 1'b0;
			end else begin
				r.valid <= 1'b1;
				r.data  <= mem_word(beat_base + 29'(beat));
				r.last  <= (beat == 7);
				r.resp  <= 2'b00;
			end
		end
	end

	initial begin
		logic [31:0] a;
		logic [31:0] prev;
		bit          missed;
		int          misses;
		int          pick;
		void'($urandom(32'h8dba_24e0));
		rst       = 1'b1;
		flush     = 1'b0;
		fetch_req = '0;
		inval     = '0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);

		// cold miss then every word of the line hits
		a = win_base | 32'h0000_0240;
		fetch_and_check("cold miss", a, missed);
		check_eq("cold miss ar", 1, missed);
		for (int w = 0; w < 16; w++) begin
			fetch_and_check("hit latency", {a[31:6], 4'(w), 2'b00}, missed);
		end

		// store to another word of the line drops it
		send_inval(a + 32'd12);
		fetch_and_check("refetch after inval", a, missed);
		check_eq("refetch after inval ar", 1, missed);
		flush_hit(a + 32'd8);

		// burst keeps running while the fetch stage moves to a cached line
		swap_during_refill(win_base | 32'h0000_3080, a + 32'd4);

		// five tags into set 5 which has only four ways
		for (int t = 0; t < 5; t++) begin
			fetch_and_check("capacity fill", win_base + 32'(t) * 32'd1024 + 32'h140, missed);
		end
		misses = 0;
		for (int t = 0; t < 5; t++) begin
			fetch_and_check("capacity reuse", win_base + 32'(t) * 32'd1024 + 32'h140, missed);
			misses += int'(missed);
		end
		check_eq("capacity refetch", 1, misses > 0);

		// random mix of new lines, same-line fetches and invalidates
		prev = a;
		for (int i = 0; i < 400; i++) begin
			pick = $urandom % 10;
			a    = win_base | ($urandom & 32'h0000_3ffc);
			if (pick < 4) begin
				a = {prev[31:6], a[5:0]};
			end
			if (pick == 9) begin
				send_inval({prev[31:6], a[5:0]});
			end else begin
				fetch_and_check("random fetch", a, missed);
				prev = a;
			end
		end

		if (i_icache_top.i_icache_sva.fail_count == 0) begin
			$display("TEST PASSED");
			$finish;
		end else begin
			abort_run($sformatf("%0d protocol assertions failed",
				i_icache_top.i_icache_sva.fail_count));
		end
	end

endmodule

`default_nettype wire

// File: verilog.f
rtl/cache_pkg.sv
rtl/axi_rd_pkg.sv
rtl/icache_tag_array.sv
rtl/icache_data_array.sv
rtl/icache_refill_ctrl.sv
rtl/icache_top.sv
testbench/icache_sva.sv
testbench/icache_tb.sv
